// File: compile.f
+incdir+.
ct_pkg.sv
ct_credit_if.sv
ct_fifo.sv
ct_rr_arb.sv
ct_tunnel_out.sv
ct_tunnel_in.sv
channel_tunnel.sv
ct_props.sv
tb_channel_tunnel.sv

// File: run.sh
#!/bin/sh
# build and run the loopback testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   -f compile.f --top-module tb_channel_tunnel

status=0
./obj_dir/Vtb_channel_tunnel > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "SIMULATION FAILED" sim.log; then
   exit 1
fi
exit 0

// File: tb_channel_tunnel.sv
////////////////////
// link output looped to link input; the stall gate hides link valid from the receive half
////////////////////
`timescale 1ns/1ps
`include "ct_cfg.svh"
`default_nettype none

module tb_channel_tunnel;
   import ct_pkg::*;

   localparam int num_lp   = `CT_NUM_IN;
   localparam int width_lp = `CT_WIDTH;
   localparam int words_lp = 200;
   localparam int dec_lp   = 1 << `CT_LG_CREDIT_DECIMATION;
   // three traffic tests of 600 words, under 2k cycles each even with stalls
   localparam int timeout_lp = 20000;

   logic                             clk;
   logic                             rst_n = 1'b0;
   logic [num_lp-1:0][width_lp-1:0]  data_i = '0;
   logic [num_lp-1:0]                v_i = '0;
   logic [num_lp-1:0]                yumi_o;
   logic [num_lp-1:0][width_lp-1:0]  data_o;
   logic [num_lp-1:0]                v_o;
   logic [num_lp-1:0]                yumi_i = '1;
   logic [LINK_W-1:0]                multi_data_o;
   logic [LINK_W-1:0]                multi_data_i;
   logic                             multi_v_o;
   logic                             multi_v_i;
   logic                             multi_yumi_i;
   logic                             multi_yumi_o;
   logic                             go = 1'b1;
   link_word_u                       link_w;

   logic [31:0]       rnd_r = 32'hcf10;
   logic              stall_en = 1'b0;
   logic              cons_rand = 1'b0;
   int                limit = 0;
   int                src_n [num_lp] = '{default: 0};
   int                rcv_n [num_lp] = '{default: 0};
   int                cred_words = 0;
   int                cycle_cnt = 0;
   int                err_cnt = 0;
   int                test_base = 0;
   int                tests_run = 0;
   int                tests_failed = 0;
   logic              held_v = 1'b0;
   logic [LINK_W-1:0] held_d = '0;

   // receive half only sees valid when the gate is open, so its yumi follows
   assign multi_data_i = multi_data_o;
   assign multi_v_i    = multi_v_o & go;
   assign multi_yumi_i = multi_yumi_o;
   assign link_w       = multi_data_o;

   channel_tunnel UUT
   (
      .clk_i        (clk),
      .rst_n_i      (rst_n),
      .data_i       (data_i),
      .v_i          (v_i),
      .yumi_o       (yumi_o),
      .data_o       (data_o),
      .v_o          (v_o),
      .yumi_i       (yumi_i),
      .multi_data_o (multi_data_o),
      .multi_v_o    (multi_v_o),
      .multi_yumi_i (multi_yumi_i),
      .multi_data_i (multi_data_i),
      .multi_v_i    (multi_v_i),
      .multi_yumi_o (multi_yumi_o)
   );

   bind channel_tunnel ct_props u_props
   (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .chan_v_i     (v_i),
      .chan_yumi_i  (yumi_o),
      .link_data_i  (multi_data_o),
      .link_v_i     (multi_v_o),
      .link_yumi_i  (multi_yumi_i),
      .fifo_v_i     (u_in.fifo_v),
      .fifo_ready_i (u_in.fifo_ready)
   );

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // word n of channel ch carries ch in the upper byte plus the running count
   function automatic logic [width_lp-1:0] exp_word(input int ch, input int n);
      return width_lp'((ch << 8) + n);
   endfunction

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic bit all_received(input int target);
      for (int ch = 0; ch < num_lp; ch++)
         if (rcv_n[ch] < target)
            return 1'b0;
      return 1'b1;
   endfunction

   task automatic show_mismatch(input string name, input logic [31:0] exp, input logic [31:0] got);
      $display("FAIL %s expected 0x%h got 0x%h", name, exp, got);
      err_cnt++;
   endtask

   task automatic show_problem(input string what);
      $display("error: %s", what);
      err_cnt++;
   endtask

   task automatic end_test(input string name);
      tests_run++;
      if (err_cnt != test_base)
         tests_failed++;
      $display("test %-16s %s, %0d errors", name,
               (err_cnt == test_base) ? "ok" : "bad", err_cnt - test_base);
      test_base = err_cnt;
   endtask

   task automatic check_quiet();
      assert (!multi_v_o && v_o == '0)
      else
         show_problem("link or channel valid high during or just after reset");
   endtask

   task automatic run_traffic(input string name, input logic stall, input logic rand_cons);
      int target;
      target = limit + words_lp;
      @(posedge clk);
      stall_en  <= stall;
      cons_rand <= rand_cons;
      limit     <= target;
      do
         @(posedge clk);
      while (!all_received(target));
      end_test(name);
   endtask

   // waits for the link to go quiet, then counts returned credit words
   task automatic drain_credits();
      int idle;
      int expect_words;
      @(posedge clk);
      stall_en  <= 1'b0;
      cons_rand <= 1'b0;
      idle = 0;
      while (idle < 8)
      begin
         @(posedge clk);
         if (multi_v_o)
            idle = 0;
         else
            idle++;
      end
      expect_words = 0;
      for (int ch = 0; ch < num_lp; ch++)
         expect_words += rcv_n[ch] / dec_lp;
      assert (cred_words == expect_words)
      else
         show_mismatch("credit words", expect_words, cred_words);
      end_test("credit return");
   endtask

   // sources and consumers, all driven on the rising edge
   always @(posedge clk)
   begin : drive
      logic [31:0] r;
      int          nxt;
      r = xorshift32(rnd_r);
      rnd_r <= r;
      go    <= stall_en ? (r[1:0] != 2'b00) : 1'b1;
      for (int ch = 0; ch < num_lp; ch++)
      begin
         nxt = src_n[ch] + ((v_i[ch] && yumi_o[ch]) ? 1 : 0);
         src_n[ch]  <= nxt;
         v_i[ch]    <= (nxt < limit);
         data_i[ch] <= exp_word(ch, nxt);
         // consumers slower than the link so credits run out
         yumi_i[ch] <= cons_rand ? (r[8 + ch] & r[12 + ch] & r[16 + ch]) : 1'b1;
      end
   end

   always @(posedge clk)
   begin : compare
      if (rst_n)
      begin
         for (int ch = 0; ch < num_lp; ch++)
         begin
            if (v_o[ch] && yumi_i[ch])
            begin
               assert (data_o[ch] == exp_word(ch, rcv_n[ch]))
               else
                  show_mismatch($sformatf("data_o[%0d]", ch), exp_word(ch, rcv_n[ch]),
                                data_o[ch]);
               rcv_n[ch] <= rcv_n[ch] + 1;
            end
            // words accepted but not yet consumed
            assert (src_n[ch] - rcv_n[ch] <= `CT_REMOTE_CREDITS)
            else
               show_problem($sformatf("channel %0d holds more words than its credits", ch));
         end
      end
   end

   always @(posedge clk)
   begin : link_watch
      if (rst_n)
      begin
         if (held_v)
         begin
            assert (multi_v_o)
            else
               show_problem("link valid dropped while the link was stalled");
            assert (multi_data_o == held_d)
            else
               show_mismatch("multi_data_o", held_d, multi_data_o);
         end
         // receive half takes every link word it sees
         assert (multi_yumi_o == multi_v_i)
         else
            show_mismatch("multi_yumi_o", multi_v_i, multi_yumi_o);
         if (multi_v_o && multi_yumi_i && link_w.credit.tag == CREDIT_TAG)
         begin
            cred_words <= cred_words + 1;
            assert (link_w.credit.count == cnt_t'(dec_lp))
            else
               show_mismatch("credit count", dec_lp, link_w.credit.count);
         end
      end
      held_v <= rst_n && multi_v_o && !multi_yumi_i;
      held_d <= multi_data_o;
   end

   always @(posedge clk)
   begin : watchdog
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= timeout_lp)
      begin
         $display("timeout: run did not finish within %0d cycles", timeout_lp);
         $display("SIMULATION FAILED");
         $finish;
      end
   end

   initial
   begin
      repeat (16)
      begin
         @(posedge clk);
         check_quiet();
      end
      rst_n <= 1'b1;
      @(posedge clk);
      check_quiet();
      end_test("reset quiet");
      run_traffic("clean link", 1'b0, 1'b0);
      run_traffic("link stalls", 1'b1, 1'b0);
      run_traffic("consumer stalls", 1'b0, 1'b1);
      drain_credits();
      $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
      if (err_cnt == 0 && tests_failed == 0)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: ct_props.sv
////////////////////
// bound into channel_tunnel; FIFO signals come from the receive half
////////////////////
`timescale 1ns/1ps
`include "ct_cfg.svh"
`default_nettype none

module ct_props
(
   input  logic                      clk_i,
   input  logic                      rst_n_i,
   input  logic [`CT_NUM_IN-1:0]     chan_v_i,
   input  logic [`CT_NUM_IN-1:0]     chan_yumi_i,
   input  logic [ct_pkg::LINK_W-1:0] link_data_i,
   input  logic                      link_v_i,
   input  logic                      link_yumi_i,
   input  logic [`CT_NUM_IN-1:0]     fifo_v_i,
   input  logic [`CT_NUM_IN-1:0]     fifo_ready_i
);

   // a stalled link word stays put until taken
   a_link_hold : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (link_v_i && !link_yumi_i) |=> (link_v_i && $stable(link_data_i)))
   else
      $error("link word changed under stall");

   a_fifo_room : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (fifo_v_i & ~fifo_ready_i) == '0)
   else
      $error("data word arrived at a full FIFO");

   a_yumi_v : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (chan_yumi_i & ~chan_v_i) == '0)
   else
      $error("channel yumi without valid");

endmodule

`default_nettype wire

// File: channel_tunnel.sv
////////////////////
// all ports valid/yumi; channel ports packed per channel
////////////////////
`timescale 1ns/1ps
`include "ct_cfg.svh"
`default_nettype none

module channel_tunnel
(
   input  logic                                clk_i,
   input  logic                                rst_n_i,
   input  logic [`CT_NUM_IN-1:0][`CT_WIDTH-1:0] data_i,
   input  logic [`CT_NUM_IN-1:0]               v_i,
   output logic [`CT_NUM_IN-1:0]               yumi_o,
   output logic [`CT_NUM_IN-1:0][`CT_WIDTH-1:0] data_o,
   output logic [`CT_NUM_IN-1:0]               v_o,
   input  logic [`CT_NUM_IN-1:0]               yumi_i,
   output logic [ct_pkg::LINK_W-1:0]           multi_data_o,
   output logic                                multi_v_o,
   input  logic                                multi_yumi_i,
   input  logic [ct_pkg::LINK_W-1:0]           multi_data_i,
   input  logic                                multi_v_i,
   output logic                                multi_yumi_o
);
   import ct_pkg::*;

   logic             credit_add_v;
   logic [TAG_W-1:0] credit_add_channel;
   cnt_t             credit_add_count;

   // credit-return requests from the receive half
   ct_credit_if cred ();

   ct_tunnel_out u_out
   (
      .clk_i                (clk_i),
      .rst_n_i              (rst_n_i),
      .data_i               (data_i),
      .v_i                  (v_i),
      .yumi_o               (yumi_o),
      .multi_data_o         (multi_data_o),
      .multi_v_o            (multi_v_o),
      .multi_yumi_i         (multi_yumi_i),
      .credit_add_v_i       (credit_add_v),
      .credit_add_channel_i (credit_add_channel),
      .credit_add_count_i   (credit_add_count),
      .cred                 (cred.tx)
   );

   ct_tunnel_in u_in
   (
      .clk_i                (clk_i),
      .rst_n_i              (rst_n_i),
      .multi_data_i         (multi_data_i),
      .multi_v_i            (multi_v_i),
      .multi_yumi_o         (multi_yumi_o),
      .data_o               (data_o),
      .v_o                  (v_o),
      .yumi_i               (yumi_i),
      .credit_add_v_o       (credit_add_v),
      .credit_add_channel_o (credit_add_channel),
      .credit_add_count_o   (credit_add_count),
      .cred                 (cred.rx)
   );

endmodule

`default_nettype wire

// File: ct_tunnel_in.sv
////////////////////
// link is always accepted; the sender's credits keep every FIFO from overflowing
////////////////////
`timescale 1ns/1ps
`include "ct_cfg.svh"
`default_nettype none

module ct_tunnel_in
(
   input  logic                                clk_i,
   input  logic                                rst_n_i,
   input  ct_pkg::link_word_u                  multi_data_i,
   input  logic                                multi_v_i,
   output logic                                multi_yumi_o,
   output logic [`CT_NUM_IN-1:0][`CT_WIDTH-1:0] data_o,
   output logic [`CT_NUM_IN-1:0]               v_o,
   input  logic [`CT_NUM_IN-1:0]               yumi_i,
   output logic                                credit_add_v_o,
   output logic [ct_pkg::TAG_W-1:0]            credit_add_channel_o,
   output ct_pkg::cnt_t                        credit_add_count_o,
   ct_credit_if.rx                             cred
);
   import ct_pkg::*;

   localparam int num_in_lp = `CT_NUM_IN;
   localparam int dec_w_lp  = (`CT_LG_CREDIT_DECIMATION > 0) ? `CT_LG_CREDIT_DECIMATION : 1;
   localparam logic [dec_w_lp-1:0] dec_last_lp = dec_w_lp'((1 << `CT_LG_CREDIT_DECIMATION) - 1);
   localparam cnt_t dec_count_lp = cnt_t'(1 << `CT_LG_CREDIT_DECIMATION);

   logic                               is_cred;
   logic [num_in_lp-1:0]               fifo_v;
   logic [num_in_lp-1:0]               fifo_ready;
   logic [num_in_lp-1:0]               taken;
   logic [num_in_lp-1:0]               dec_wrap;
   logic [num_in_lp-1:0]               take;
   logic [num_in_lp-1:0][dec_w_lp-1:0] dec_r;
   cnt_t [num_in_lp-1:0]               pend_r;
   logic                               sel_v;
   logic [TAG_W-1:0]                   sel_ch;
   logic                               load;
   logic                               cred_v_r;
   logic [TAG_W-1:0]                   cred_ch_r;

   assign multi_yumi_o = multi_v_i;
   assign is_cred      = (multi_data_i.data.tag == CREDIT_TAG);

   // credit words bypass the FIFOs to the send half
   assign credit_add_v_o       = multi_v_i & is_cred;
   assign credit_add_channel_o = multi_data_i.credit.channel;
   assign credit_add_count_o   = multi_data_i.credit.count;

   for (genvar i = 0; i < num_in_lp; i++)
   begin : g_ch
      assign fifo_v[i] = multi_v_i & ~is_cred & (multi_data_i.data.tag == TAG_W'(i));

      ct_fifo #(.depth_p(`CT_REMOTE_CREDITS), .width_p(`CT_WIDTH)) u_fifo
      (
         .clk_i   (clk_i),
         .rst_n_i (rst_n_i),
         .data_i  (multi_data_i.data.payload),
         .v_i     (fifo_v[i]),
         .ready_o (fifo_ready[i]),
         .data_o  (data_o[i]),
         .v_o     (v_o[i]),
         .yumi_i  (yumi_i[i])
      );

      assign taken[i]    = yumi_i[i] & v_o[i];
      assign dec_wrap[i] = taken[i] & (dec_r[i] == dec_last_lp);
      assign take[i]     = load & (sel_ch == TAG_W'(i));
   end

   // lowest channel with a pending credit word
   always_comb
   begin
      sel_v  = 1'b0;
      sel_ch = '0;
      for (int i = num_in_lp - 1; i >= 0; i--)
      begin
         if (pend_r[i] != '0)
         begin
            sel_v  = 1'b1;
            sel_ch = TAG_W'(i);
         end
      end
   end

   assign load = sel_v & (~cred_v_r | cred.yumi);

   assign cred.v       = cred_v_r;
   assign cred.channel = cred_ch_r;
   assign cred.count   = dec_count_lp;

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         dec_r     <= '0;
         pend_r    <= '0;
         cred_v_r  <= 1'b0;
         cred_ch_r <= '0;
      end
      else
      begin
         for (int i = 0; i < num_in_lp; i++)
         begin
            if (taken[i])
               dec_r[i] <= dec_wrap[i] ? '0 : dec_r[i] + 1'b1;
            pend_r[i] <= pend_r[i] + cnt_t'(dec_wrap[i]) - cnt_t'(take[i]);
         end
         // request register only reloads once the old word has gone
         if (~cred_v_r | cred.yumi)
         begin
            cred_v_r  <= sel_v;
            cred_ch_r <= sel_ch;
         end
      end
   end

endmodule

`default_nettype wire

// File: ct_tunnel_out.sv
////////////////////
// link idles for one cycle out of reset; a stalled word is held until taken
////////////////////
`timescale 1ns/1ps
`include "ct_cfg.svh"
`default_nettype none

module ct_tunnel_out
(
   input  logic                                clk_i,
   input  logic                                rst_n_i,
   input  logic [`CT_NUM_IN-1:0][`CT_WIDTH-1:0] data_i,
   input  logic [`CT_NUM_IN-1:0]               v_i,
   output logic [`CT_NUM_IN-1:0]               yumi_o,
   output ct_pkg::link_word_u                  multi_data_o,
   output logic                                multi_v_o,
   input  logic                                multi_yumi_i,
   input  logic                                credit_add_v_i,
   input  logic [ct_pkg::TAG_W-1:0]            credit_add_channel_i,
   input  ct_pkg::cnt_t                        credit_add_count_i,
   ct_credit_if.tx                             cred
);
   import ct_pkg::*;

   localparam int num_in_lp = `CT_NUM_IN;

   cnt_t [num_in_lp-1:0] cnt_r;
   logic [num_in_lp-1:0] has_cred;
   logic [num_in_lp-1:0] req;
   logic [num_in_lp-1:0] arb_grant;
   logic [num_in_lp-1:0] grant;
   logic [num_in_lp-1:0] grant_r;
   logic                 live_r;
   logic                 stall_r;
   logic                 cred_sel_r;
   logic                 cred_sel;

   always_comb
   begin
      for (int i = 0; i < num_in_lp; i++)
         has_cred[i] = (cnt_r[i] != '0);
   end

   // during a stall only the held channel may request
   assign req = stall_r ? grant_r : (v_i & has_cred & {num_in_lp{live_r}});

   ct_rr_arb #(.n_p(num_in_lp)) u_arb
   (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .req_i     (req),
      .grant_o   (arb_grant),
      .advance_i (|yumi_o)
   );

   // credit words go first unless a data word is already on the link
   assign cred_sel   = stall_r ? cred_sel_r : cred.v;
   assign grant      = cred_sel ? '0 : arb_grant;
   assign multi_v_o  = cred_sel | (|grant);
   assign cred.yumi  = cred_sel & multi_yumi_i;
   assign yumi_o     = grant & {num_in_lp{multi_yumi_i}};

   always_comb
   begin
      multi_data_o = '0;
      if (cred_sel)
      begin
         multi_data_o.credit.tag     = CREDIT_TAG;
         multi_data_o.credit.channel = cred.channel;
         multi_data_o.credit.count   = cred.count;
      end
      else
      begin
         for (int i = 0; i < num_in_lp; i++)
         begin
            if (grant[i])
            begin
               multi_data_o.data.tag     = TAG_W'(i);
               multi_data_o.data.payload = data_i[i];
            end
         end
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         for (int i = 0; i < num_in_lp; i++)
            cnt_r[i] <= cnt_t'(`CT_REMOTE_CREDITS);
         live_r     <= 1'b0;
         stall_r    <= 1'b0;
         cred_sel_r <= 1'b0;
         grant_r    <= '0;
      end
      else
      begin
         live_r     <= 1'b1;
         stall_r    <= multi_v_o & ~multi_yumi_i;
         cred_sel_r <= cred_sel;
         grant_r    <= grant;
         // sent words take a credit, returned credit words add theirs
         for (int i = 0; i < num_in_lp; i++)
            cnt_r[i] <= cnt_r[i] - cnt_t'(yumi_o[i])
                        + ((credit_add_v_i && credit_add_channel_i == TAG_W'(i))
                           ? credit_add_count_i : '0);
      end
   end

endmodule

`default_nettype wire

// File: ct_rr_arb.sv
////////////////////
// channel 0 wins first after reset
////////////////////
`timescale 1ns/1ps
`default_nettype none

module ct_rr_arb
#(
   parameter int n_p = 3
)
(
   input  logic           clk_i,
   input  logic           rst_n_i,
   input  logic [n_p-1:0] req_i,
   output logic [n_p-1:0] grant_o,
   input  logic           advance_i
);

   localparam int idx_w_lp = (n_p > 1) ? $clog2(n_p) : 1;

   logic [idx_w_lp-1:0] last_r;
   logic [idx_w_lp-1:0] grant_idx;

   // search starts just past the last winner
   always_comb
   begin
      int   idx;
      logic found;
      grant_o   = '0;
      grant_idx = last_r;
      found     = 1'b0;
      for (int k = 1; k <= n_p; k++)
      begin
         idx = (int'(last_r) + k) % n_p;
         if (!found && req_i[idx])
         begin
            grant_o[idx] = 1'b1;
            grant_idx    = idx_w_lp'(idx);
            found        = 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
         last_r <= idx_w_lp'(n_p - 1);
      else if (advance_i)
         last_r <= grant_idx;
   end

endmodule

`default_nettype wire

// File: ct_fifo.sv
////////////////////
// writes while full are dropped; the tunnel's credits prevent them
////////////////////
`timescale 1ns/1ps
`default_nettype none

module ct_fifo
#(
   parameter int depth_p = 4,
   parameter int width_p = 16
)
(
   input  logic               clk_i,
   input  logic               rst_n_i,
   input  logic [width_p-1:0] data_i,
   input  logic               v_i,
   output logic               ready_o,
   output logic [width_p-1:0] data_o,
   output logic               v_o,
   input  logic               yumi_i
);

   localparam int ptr_w_lp = (depth_p > 1) ? $clog2(depth_p) : 1;
   localparam int cnt_w_lp = $clog2(depth_p + 1);

   logic [width_p-1:0]  mem [depth_p];
   logic [ptr_w_lp-1:0] wr_ptr_r;
   logic [ptr_w_lp-1:0] rd_ptr_r;
   logic [cnt_w_lp-1:0] count_r;
   logic                wr;
   logic                rd;

   function automatic logic [ptr_w_lp-1:0] next_ptr(input logic [ptr_w_lp-1:0] p);
      return (p == ptr_w_lp'(depth_p - 1)) ? '0 : p + 1'b1;
   endfunction

   assign ready_o = (count_r != cnt_w_lp'(depth_p));
   // head word and valid come straight from flops
   assign v_o     = (count_r != '0);
   assign data_o  = mem[rd_ptr_r];
   assign wr      = v_i & ready_o;
   assign rd      = yumi_i & v_o;

   always_ff @(posedge clk_i)
   begin
      if (wr)
         mem[wr_ptr_r] <= data_i;
   end

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         wr_ptr_r <= '0;
         rd_ptr_r <= '0;
         count_r  <= '0;
      end
      else
      begin
         if (wr)
            wr_ptr_r <= next_ptr(wr_ptr_r);
         if (rd)
            rd_ptr_r <= next_ptr(rd_ptr_r);
         count_r <= count_r + cnt_w_lp'(wr) - cnt_w_lp'(rd);
      end
   end

endmodule

`default_nettype wire

// File: ct_credit_if.sv
////////////////////
// valid/yumi, rx holds fields stable until yumi
////////////////////
`timescale 1ns/1ps
`default_nettype none

interface ct_credit_if;
   import ct_pkg::*;

   // credit word request from the receive half
   logic             v;
   logic [TAG_W-1:0] channel;
   cnt_t             count;
   // taken when the credit word leaves on the link
   logic             yumi;

   modport rx (output v, output channel, output count, input yumi);
   modport tx (input v, input channel, input count, output yumi);

endinterface

`default_nettype wire

// File: ct_pkg.sv
////////////////////
// credit view needs TAG_W + CNT_W bits of payload width
////////////////////
`include "ct_cfg.svh"
`default_nettype none

package ct_pkg;

   localparam int TAG_W  = $clog2(`CT_NUM_IN + 1);
   localparam int LINK_W = TAG_W + `CT_WIDTH;
   localparam int CNT_W  = $clog2(`CT_REMOTE_CREDITS + 1);
   localparam int PAD_W  = `CT_WIDTH - TAG_W - CNT_W;

   // highest tag code marks a credit-return word
   localparam logic [TAG_W-1:0] CREDIT_TAG = TAG_W'(`CT_NUM_IN);

   typedef logic [CNT_W-1:0] cnt_t;

   typedef struct packed {
      logic [TAG_W-1:0]    tag;
      logic [`CT_WIDTH-1:0] payload;
   } data_view_t;

   // pad sits above channel and count
   typedef struct packed {
      logic [TAG_W-1:0] tag;
      logic [PAD_W-1:0] pad;
      logic [TAG_W-1:0] channel;
      cnt_t             count;
   } credit_view_t;

   typedef union packed {
      data_view_t   data;
      credit_view_t credit;
   } link_word_u;

endpackage

`default_nettype wire

// File: ct_cfg.svh
////////////////////
// tag is sized for CT_NUM_IN+1 codes; 2**CT_LG_CREDIT_DECIMATION must not exceed
// CT_REMOTE_CREDITS, and the credit fields must fit inside CT_WIDTH
////////////////////
`ifndef CT_CFG_SVH
`define CT_CFG_SVH

// payload bits per channel word
`define CT_WIDTH 16
`define CT_NUM_IN 3
// receive FIFO depth, also the initial credits
`define CT_REMOTE_CREDITS 4
`define CT_LG_CREDIT_DECIMATION 1

`endif
